// File: Bender.yml
package:
  name: emu_board

sources:
  - files:
      - hdl/frame_pkg.sv
      - hdl/joy_if.sv
      - hdl/pll_guard.sv
      - hdl/reset_seq.sv
      - hdl/db15_reader.sv
      - hdl/input_merge.sv
      - hdl/emu_board.sv
  - target: simulation
    files:
      - sim/db15_pad_model.sv
      - sim/tb_emu_board.sv

// File: hdl/db15_reader.sv
// SNAC DB15 adapter reader
`timescale 1ns/10ps

module db15_reader import frame_pkg::*; #(
    parameter int JOY_DIV = 4
) (
    input  logic  clk_sys,
    input  logic  RESET,
    input  logic  joy_data,
    joy_if.reader joy
);

// Two load half periods, then two per data bit
localparam int HALVES = 2 * (DB15_BITS + 1);
localparam int HALF_W = $clog2(HALVES);
localparam int DIV_W  = (JOY_DIV > 1) ? $clog2(JOY_DIV) : 1;

logic [DIV_W-1:0]     div_cnt;
logic [DIV_W-1:0]     div_nxt;
logic [HALF_W-1:0]    half_cnt;
logic [HALF_W-1:0]    half_nxt;
logic                 half_end;
logic                 sample;
logic                 last_bit;
logic                 data_s1;
logic                 data_s2;
logic [DB15_BITS-1:0] shreg;
logic [DB15_BITS-1:0] word_nxt;

//////////////////////////////////////////////////////////////////////
// Frame sequencer

assign half_end = div_cnt == DIV_W'(JOY_DIV - 1);

always_comb begin
    div_nxt  = half_end ? '0 : div_cnt + 1'b1;
    half_nxt = half_cnt;
    if (half_end) begin
        half_nxt = (half_cnt == HALF_W'(HALVES - 1)) ? '0 : half_cnt + 1'b1;
    end
end

// Rising edge of joy_clk, odd half periods past the load
assign sample   = joy.enable && half_end && half_nxt[0] && half_nxt != HALF_W'(1);
assign last_bit = sample && half_nxt == HALF_W'(HALVES - 1);

// Wire data is active low, bit 0 arrives first
assign word_nxt = {~data_s2, shreg[DB15_BITS-1:1]};

always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
        // Parked on the last half so the first edge starts a load
        div_cnt        <= DIV_W'(JOY_DIV - 1);
        half_cnt       <= HALF_W'(HALVES - 1);
        joy.joy_load   <= 1'b0;
        joy.joy_clk    <= 1'b0;
        joy.frame_done <= 1'b0;
        joy.p1         <= '0;
        joy.p2         <= '0;
    end else if (!joy.enable) begin
        div_cnt        <= DIV_W'(JOY_DIV - 1);
        half_cnt       <= HALF_W'(HALVES - 1);
        joy.joy_load   <= 1'b0;
        joy.joy_clk    <= 1'b0;
        joy.frame_done <= 1'b0;
        joy.p1         <= '0;
        joy.p2         <= '0;
    end else begin
        div_cnt        <= div_nxt;
        half_cnt       <= half_nxt;
        joy.joy_load   <= half_nxt < HALF_W'(2);
        joy.joy_clk    <= half_nxt[0] && half_nxt != HALF_W'(1);
        joy.frame_done <= last_bit;
        // Both players change together
        if (last_bit) begin
            joy.p1 <= joy_t'(word_nxt[DB15_BITS/2-1:0]);
            joy.p2 <= joy_t'(word_nxt[DB15_BITS-1:DB15_BITS/2]);
        end
    end
end

//////////////////////////////////////////////////////////////////////
// Data pin synchronizer and shift register

always_ff @(posedge clk_sys) begin
    data_s1 <= joy_data;
    data_s2 <= data_s1;
    if (sample) begin
        shreg <= word_nxt;
    end
end

endmodule

// File: hdl/emu_board.sv
// Board support top level
`timescale 1ns/10ps

module emu_board import frame_pkg::*; #(
    parameter int PLL_HOLD    = 256,
    parameter int RST_STRETCH = 16,
    parameter int JOY_DIV     = 4
) (
    input  logic        clk_sys,
    input  logic        RESET,
    input  logic        pll_locked,
    input  logic [31:0] status,
    input  logic [1:0]  buttons,
    input  logic        downloading,
    input  joy_t        usb_joy1,
    input  joy_t        usb_joy2,
    input  logic [6:0]  user_in,
    output logic        pll_rst,
    output logic        game_rst,
    output joy_t        game_joy1,
    output joy_t        game_joy2,
    output logic [1:0]  game_coin,
    output logic [1:0]  game_start,
    output logic        user_mode,
    output logic [6:0]  user_out
);

joy_if u_joy ();

//////////////////////////////////////////////////////////////////////
// Clock and reset

pll_guard #(
    .PLL_HOLD     ( PLL_HOLD    )
) u_pll_guard (
    .clk_sys      ( clk_sys     ),
    .RESET        ( RESET       ),
    .pll_locked   ( pll_locked  ),
    .pll_rst      ( pll_rst     )
);

// OSD reset is status[0], board button on buttons[1]
reset_seq #(
    .RST_STRETCH  ( RST_STRETCH )
) u_reset_seq (
    .clk_sys      ( clk_sys     ),
    .RESET        ( RESET       ),
    .osd_reset    ( status[0]   ),
    .button_reset ( buttons[1]  ),
    .downloading  ( downloading ),
    .pll_locked   ( pll_locked  ),
    .game_rst     ( game_rst    )
);

//////////////////////////////////////////////////////////////////////
// SNAC joystick path

db15_reader #(
    .JOY_DIV      ( JOY_DIV                )
) u_db15_reader (
    .clk_sys      ( clk_sys                ),
    .RESET        ( RESET                  ),
    .joy_data     ( user_in[USER_DATA_BIT] ),
    .joy          ( u_joy                  )
);

input_merge u_input_merge (
    .clk_sys      ( clk_sys        ),
    .RESET        ( RESET          ),
    .mode_bits    ( status[31:30]  ),
    .usb_joy1     ( usb_joy1       ),
    .usb_joy2     ( usb_joy2       ),
    .joy          ( u_joy          ),
    .game_joy1    ( game_joy1      ),
    .game_joy2    ( game_joy2      ),
    .game_coin    ( game_coin      ),
    .game_start   ( game_start     ),
    .user_mode    ( user_mode      ),
    .user_out     ( user_out       )
);

endmodule

// File: hdl/frame_pkg.sv
// Board support shared definitions
package frame_pkg;

    //////////////////////////////////////////////////////////////////////
    // Joystick word

    // One player, active high, bit 0 first
    typedef logic [7:0] joy_t;

    localparam int JOY_RIGHT = 0;
    localparam int JOY_LEFT  = 1;
    localparam int JOY_DOWN  = 2;
    localparam int JOY_UP    = 3;
    localparam int JOY_B1    = 4;
    localparam int JOY_B2    = 5;
    localparam int JOY_START = 6;
    localparam int JOY_COIN  = 7;

    //////////////////////////////////////////////////////////////////////
    // SNAC DB15 adapter

    // From status[31:30], value 3 behaves as two players
    typedef enum logic [1:0] {
        DB15_OFF = 2'd0,
        DB15_ONE = 2'd1,
        DB15_TWO = 2'd2
    } db15_mode_t;

    // Data bits per adapter frame, player 1 in the low byte
    localparam int DB15_BITS = 16;

    // User port pin positions
    localparam int USER_DATA_BIT = 5;
    localparam int USER_LOAD_BIT = 0;
    localparam int USER_CLK_BIT  = 1;

endpackage

// File: hdl/input_merge.sv
// Joystick merge and user port drive
`timescale 1ns/10ps

module input_merge import frame_pkg::*; (
    input  logic       clk_sys,
    input  logic       RESET,
    input  logic [1:0] mode_bits,
    input  joy_t       usb_joy1,
    input  joy_t       usb_joy2,
    joy_if.merge       joy,
    output joy_t       game_joy1,
    output joy_t       game_joy2,
    output logic [1:0] game_coin,
    output logic [1:0] game_start,
    output logic       user_mode,
    output logic [6:0] user_out
);

db15_mode_t mode;
logic       db15_valid;
joy_t       p1_act;
joy_t       p2_act;
joy_t       joy1_nxt;
joy_t       joy2_nxt;
logic [6:0] out_nxt;

// Mode 3 falls through to two players
always_comb begin
    case (mode_bits)
        2'd0:    mode = DB15_OFF;
        2'd1:    mode = DB15_ONE;
        default: mode = DB15_TWO;
    endcase
end

assign joy.enable = mode != DB15_OFF;

// DB15 words only count once a full frame has been read
assign p1_act   = (joy.enable && db15_valid) ? joy.p1 : '0;
assign p2_act   = (mode == DB15_TWO && db15_valid) ? joy.p2 : '0;
assign joy1_nxt = usb_joy1 | p1_act;
assign joy2_nxt = usb_joy2 | p2_act;

// Adapter strobes on the user port, released high otherwise
always_comb begin
    out_nxt = '1;
    if (joy.enable) begin
        out_nxt[USER_LOAD_BIT] = joy.joy_load;
        out_nxt[USER_CLK_BIT]  = joy.joy_clk;
    end
end

//////////////////////////////////////////////////////////////////////
// Output registers

always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
        db15_valid <= 1'b0;
        game_joy1  <= '0;
        game_joy2  <= '0;
        game_coin  <= '0;
        game_start <= '0;
        user_mode  <= 1'b0;
        user_out   <= '1;
    end else begin
        if (!joy.enable) begin
            db15_valid <= 1'b0;
        end else if (joy.frame_done) begin
            db15_valid <= 1'b1;
        end
        game_joy1  <= joy1_nxt;
        game_joy2  <= joy2_nxt;
        game_coin  <= {joy2_nxt[JOY_COIN], joy1_nxt[JOY_COIN]};
        game_start <= {joy2_nxt[JOY_START], joy1_nxt[JOY_START]};
        user_mode  <= joy.enable;
        user_out   <= out_nxt;
    end
end

endmodule

// File: hdl/joy_if.sv
// DB15 reader link
`timescale 1ns/10ps

interface joy_if import frame_pkg::*; ();

    logic joy_clk;
    logic joy_load;
    joy_t p1;
    joy_t p2;
    // One cycle, same edge as the p1/p2 update
    logic frame_done;
    logic enable;

    modport reader (
        output joy_clk, joy_load, p1, p2, frame_done,
        input  enable
    );

    modport merge (
        input  joy_clk, joy_load, p1, p2, frame_done,
        output enable
    );

endinterface

// File: hdl/pll_guard.sv
// PLL lock watchdog
`timescale 1ns/10ps

module pll_guard #(
    parameter int PLL_HOLD = 256
) (
    input  logic clk_sys,
    input  logic RESET,
    input  logic pll_locked,
    output logic pll_rst
);

localparam int CNT_W = $clog2(PLL_HOLD + 1);

logic             lock_q;
logic             lock_d;
logic             lock_lost;
logic [CNT_W-1:0] hold_cnt;

//////////////////////////////////////////////////////////////////////
// Lock loss detection

// Falling edge of the registered lock level
assign lock_lost = lock_d & ~lock_q;

//////////////////////////////////////////////////////////////////////
// Hold counter

always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
        lock_q   <= 1'b0;
        lock_d   <= 1'b0;
        hold_cnt <= '0;
    end else begin
        lock_q <= pll_locked;
        lock_d <= lock_q;
        // Restarts on every new loss, even mid-hold
        if (lock_lost) begin
            hold_cnt <= CNT_W'(PLL_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end
end

// PLL held in reset while counting down
assign pll_rst = hold_cnt != '0;

endmodule

// File: hdl/reset_seq.sv
// Game reset sequencer
`timescale 1ns/10ps

module reset_seq #(
    parameter int RST_STRETCH = 16
) (
    input  logic clk_sys,
    input  logic RESET,
    input  logic osd_reset,
    input  logic button_reset,
    input  logic downloading,
    input  logic pll_locked,
    output logic game_rst
);

localparam int CNT_W = $clog2(RST_STRETCH + 1);

logic             req;
logic [CNT_W-1:0] stretch_cnt;

// Any source that must keep the game in reset
assign req = osd_reset | button_reset | downloading | ~pll_locked;

//////////////////////////////////////////////////////////////////////
// Stretch counter

always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
        stretch_cnt <= CNT_W'(RST_STRETCH);
        game_rst    <= 1'b1;
    end else if (req) begin
        // Reload on every request cycle
        stretch_cnt <= CNT_W'(RST_STRETCH);
        game_rst    <= 1'b1;
    end else if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
        // Release on the edge where the count runs out
        game_rst    <= stretch_cnt != CNT_W'(1);
    end else begin
        game_rst <= 1'b0;
    end
end

endmodule

// File: sim.f
hdl/frame_pkg.sv
hdl/joy_if.sv
hdl/pll_guard.sv
hdl/reset_seq.sv
hdl/db15_reader.sv
hdl/input_merge.sv
hdl/emu_board.sv
sim/db15_pad_model.sv
sim/tb_emu_board.sv

// File: sim/db15_pad_model.sv
// DB15 adapter shift chain model
`timescale 1ns/10ps

module db15_pad_model import frame_pkg::*; (
    input  logic                 load_pin,
    input  logic                 clk_pin,
    input  logic [DB15_BITS-1:0] pattern,
    output logic                 data_pin
);

localparam int POS_W = $clog2(DB15_BITS);

logic [DB15_BITS-1:0] frame_bits = '0;
logic [POS_W-1:0]     pos = '0;

// Parallel inputs captured as the load strobe ends
always @(negedge load_pin) begin
    frame_bits <= pattern;
end

// Bit index, cleared by load, advanced on each falling clock
always @(negedge clk_pin or posedge load_pin) begin
    if (load_pin) begin
        pos <= '0;
    end else begin
        pos <= pos + 1'b1;
    end
end

// Bit 0 shows through while loading, pressed buttons pull the line low
assign data_pin = load_pin ? ~pattern[0] : ~frame_bits[pos];

endmodule

// File: sim/tb_emu_board.sv
// Board support testbench
`timescale 1ns/10ps

module tb_emu_board import frame_pkg::*; ();

localparam int PLL_HOLD    = 32;
localparam int RST_STRETCH = 16;
localparam int JOY_DIV     = 4;
localparam int FRAME_CYC   = (DB15_BITS + 1) * 2 * JOY_DIV;
localparam int N_OFF       = 40;
localparam int N_ONE       = 4;
localparam int N_TWO       = 4;
// Frames of the DB15 tests, then reset and hold periods, 50 percent margin
localparam int TEST_FRAMES = 2 * N_ONE + 2 * 2 * N_TWO + 2;
localparam int HOLD_CYC    = 10 + PLL_HOLD + 4 * (RST_STRETCH + 4) + N_OFF;
localparam int WATCH_CYC   = (TEST_FRAMES * FRAME_CYC + HOLD_CYC) * 3 / 2;

typedef struct packed {
    joy_t       joy1;
    joy_t       joy2;
    logic [1:0] coin;
    logic [1:0] start;
    logic       mode_on;
    logic [6:0] pins;
    logic [6:0] pin_mask;
} merge_exp_t;

logic                 clk_sys;
logic                 RESET;
logic                 pll_locked;
logic [31:0]          status;
logic [1:0]           buttons;
logic                 downloading;
joy_t                 usb_joy1;
joy_t                 usb_joy2;
wire  [6:0]           user_in;
logic                 pll_rst;
logic                 game_rst;
joy_t                 game_joy1;
joy_t                 game_joy2;
logic [1:0]           game_coin;
logic [1:0]           game_start;
logic                 user_mode;
logic [6:0]           user_out;
logic [DB15_BITS-1:0] pattern;
logic                 pad_data;
logic [31:0]          rng;
merge_exp_t           exp_q;
string                check_name;
event                 check_ev;

// Unused user port lines idle high
assign user_in = {1'b1, pad_data, 5'b11111};

emu_board #(
    .PLL_HOLD    ( PLL_HOLD    ),
    .RST_STRETCH ( RST_STRETCH ),
    .JOY_DIV     ( JOY_DIV     )
) u_dut (
    .clk_sys     ( clk_sys     ),
    .RESET       ( RESET       ),
    .pll_locked  ( pll_locked  ),
    .status      ( status      ),
    .buttons     ( buttons     ),
    .downloading ( downloading ),
    .usb_joy1    ( usb_joy1    ),
    .usb_joy2    ( usb_joy2    ),
    .user_in     ( user_in     ),
    .pll_rst     ( pll_rst     ),
    .game_rst    ( game_rst    ),
    .game_joy1   ( game_joy1   ),
    .game_joy2   ( game_joy2   ),
    .game_coin   ( game_coin   ),
    .game_start  ( game_start  ),
    .user_mode   ( user_mode   ),
    .user_out    ( user_out    )
);

db15_pad_model u_pad (
    .load_pin ( user_out[USER_LOAD_BIT] ),
    .clk_pin  ( user_out[USER_CLK_BIT]  ),
    .pattern  ( pattern                 ),
    .data_pin ( pad_data                )
);

initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
end

initial begin
    repeat (WATCH_CYC) @(posedge clk_sys);
    $display("Timeout: tests did not finish within %0d clock cycles", WATCH_CYC);
    end_with_failure();
end

//////////////////////////////////////////////////////////////////////
// Reference model and compare tasks

function automatic merge_exp_t expected_inputs(input logic [1:0] mode, input joy_t u1,
                                               input joy_t u2, input logic [15:0] pat);
    merge_exp_t e;
    joy_t       pad1;
    joy_t       pad2;
    // Player 1 in any DB15 mode, player 2 for modes 2 and 3
    pad1 = (mode != 2'd0) ? pat[7:0] : '0;
    pad2 = mode[1] ? pat[15:8] : '0;
    e.joy1    = u1 | pad1;
    e.joy2    = u2 | pad2;
    e.coin    = {e.joy2[JOY_COIN], e.joy1[JOY_COIN]};
    e.start   = {e.joy2[JOY_START], e.joy1[JOY_START]};
    e.mode_on = mode != 2'd0;
    e.pins    = '1;
    e.pin_mask = '1;
    // Strobe pins follow the adapter frame
    if (e.mode_on) begin
        e.pin_mask[USER_LOAD_BIT] = 1'b0;
        e.pin_mask[USER_CLK_BIT]  = 1'b0;
    end
    return e;
endfunction

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic end_with_failure();
    $display("Something failed");
    $fatal(1, "Simulation stopped at first error");
endtask

task automatic check_joy(input string name, input joy_t exp, input joy_t act);
    if (act !== exp) begin
        $display("ERR %s: expected %h, actual %h", name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_bits(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
        $display("ERR %s: expected %b, actual %b", name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s: expected %b, actual %b", name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_pins(input string name, input logic [6:0] exp, input logic [6:0] act);
    if (act !== exp) begin
        $display("ERR %s: expected %b, actual %b", name, exp, act);
        end_with_failure();
    end
endtask

// Merge outputs against the reference, on request from the stimulus
always @(check_ev) begin
    check_joy({check_name, " game_joy1"}, exp_q.joy1, game_joy1);
    check_joy({check_name, " game_joy2"}, exp_q.joy2, game_joy2);
    check_bits({check_name, " game_coin"}, exp_q.coin, game_coin);
    check_bits({check_name, " game_start"}, exp_q.start, game_start);
    check_level({check_name, " user_mode"}, exp_q.mode_on, user_mode);
    check_pins({check_name, " user_out"}, exp_q.pins & exp_q.pin_mask,
               user_out & exp_q.pin_mask);
end

//////////////////////////////////////////////////////////////////////
// Stimulus helpers

task automatic request_check(input string name);
    exp_q      = expected_inputs(status[31:30], usb_joy1, usb_joy2, pattern);
    check_name = name;
    -> check_ev;
endtask

task automatic draw_inputs();
    rng      = lcg_step(rng);
    usb_joy1 = rng[31:24];
    rng      = lcg_step(rng);
    usb_joy2 = rng[31:24];
    rng      = lcg_step(rng);
    pattern  = rng[31:16];
endtask

// Falls on the RST_STRETCH-th edge once requests are gone
task automatic expect_stretch(input string name);
    for (int i = 1; i <= RST_STRETCH; i++) begin
        @(negedge clk_sys);
        check_level({name, " game_rst"}, i < RST_STRETCH, game_rst);
    end
endtask

task automatic set_source(input int src, input logic level);
    case (src)
        0:       status[0]   = level;
        1:       buttons[1]  = level;
        default: downloading = level;
    endcase
endtask

task automatic pulse_reset_source(input int src, input string name);
    set_source(src, 1'b1);
    repeat (3) begin
        @(negedge clk_sys);
        check_level({name, " asserted game_rst"}, 1'b1, game_rst);
    end
    set_source(src, 1'b0);
    expect_stretch(name);
endtask

// Returns on the first falling edge that sees a new load strobe
task automatic wait_load_start();
    int   n;
    logic seen_low;
    n        = 0;
    seen_low = 1'b0;
    while (!(seen_low && user_out[USER_LOAD_BIT] === 1'b1)) begin
        if (user_out[USER_LOAD_BIT] === 1'b0) begin
            seen_low = 1'b1;
        end
        if (n > 2 * FRAME_CYC) begin
            $display("No adapter load strobe seen on user_out");
            end_with_failure();
        end
        @(negedge clk_sys);
        n++;
    end
endtask

//////////////////////////////////////////////////////////////////////
// Test sequence

task automatic test_lock_loss();
    pll_locked = 1'b0;
    @(negedge clk_sys);
    check_level("lock_loss first edge pll_rst", 1'b0, pll_rst);
    check_level("lock_loss game_rst", 1'b1, game_rst);
    for (int i = 1; i <= PLL_HOLD; i++) begin
        @(negedge clk_sys);
        check_level("lock_loss hold pll_rst", 1'b1, pll_rst);
        check_level("lock_loss game_rst", 1'b1, game_rst);
    end
    @(negedge clk_sys);
    check_level("lock_loss end pll_rst", 1'b0, pll_rst);
    pll_locked = 1'b1;
    expect_stretch("relock");
endtask

task automatic run_db15_mode(input logic [1:0] mode, input string name);
    status[31:30] = mode;
    for (int i = 0; i < N_TWO; i++) begin
        // New pattern during load is read by the frame that follows
        wait_load_start();
        draw_inputs();
        repeat (FRAME_CYC + 2) @(negedge clk_sys);
        request_check(name);
    end
endtask

initial begin
    RESET       = 1'b1;
    pll_locked  = 1'b1;
    status      = '0;
    buttons     = '0;
    downloading = 1'b0;
    usb_joy1    = '0;
    usb_joy2    = '0;
    pattern     = '0;
    rng         = 32'd86;
    check_name  = "";
    repeat (10) @(negedge clk_sys);
    RESET = 1'b0;
    check_level("reset pll_rst", 1'b0, pll_rst);
    check_level("reset game_rst", 1'b1, game_rst);
    check_level("reset user_mode", 1'b0, user_mode);
    check_pins("reset user_out", 7'h7f, user_out);
    check_joy("reset game_joy1", 8'h00, game_joy1);
    check_bits("reset game_coin", 2'b00, game_coin);
    expect_stretch("reset release");
    test_lock_loss();
    pulse_reset_source(0, "osd_reset");
    pulse_reset_source(1, "button_reset");
    pulse_reset_source(2, "downloading");
    // USB words pass straight through, one cycle late
    for (int i = 0; i < N_OFF; i++) begin
        draw_inputs();
        @(negedge clk_sys);
        request_check("db15_off");
    end
    status[31:30] = 2'd1;
    for (int i = 0; i < N_ONE; i++) begin
        draw_inputs();
        repeat (2 * FRAME_CYC + 4) @(negedge clk_sys);
        request_check("db15_one");
    end
    run_db15_mode(2'd2, "db15_two");
    run_db15_mode(2'd3, "db15_mode3");
    repeat (2) @(negedge clk_sys);
    $display("Everything OK");
    $finish;
end

endmodule
